//--- source/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h1c000000

// packets buffered between predictor and issuer
`define FETCH_QUEUE_DEPTH 4

// direct mapped btb, indexed by pc[8:3]
`define BTB_ADDR_WIDTH 6
`define BTB_TAG_WIDTH 8

// local history table
`define BHT_ADDR_WIDTH 5
`define BHT_DATA_WIDTH 4

// pattern table index is 2 pc bits plus the local history
`define LPHT_ADDR_WIDTH 6

// return address stack, 8 entries
`define RAS_PTR_WIDTH 3

`endif

//--- source/bpu_pkg.sv
`default_nettype none
`include "fetch_settings.svh"

package bpu_pkg;

  // how the next pc is formed after a branch
  typedef enum logic [1:0] {
    NPC    = 2'd0,
    CALL   = 2'd1,
    RETURN = 2'd2,
    JUMP   = 2'd3
  } target_type_e;

  typedef struct packed {
    // branch sits in slot 1
    logic                      fsc;
    logic [29:0]               target;
    logic [`BTB_TAG_WIDTH-1:0] tag;
    // unconditional branch
    logic                      dir_type;
    target_type_e              branch_type;
  } btb_entry_t;

  // travels with each packet so execute can train and repair
  typedef struct packed {
    logic [`RAS_PTR_WIDTH-1:0]  ras_ptr;
    logic [`BHT_DATA_WIDTH-1:0] history;
    logic [1:0]                 lphr;
    logic                       taken;
  } predict_meta_t;

  typedef struct packed {
    logic                       miss;
    logic [31:0]                pc;
    logic [31:0]                true_target;
    target_type_e               true_target_type;
    // high for an unconditional branch, as in the btb
    logic                       true_dir;
    logic                       true_taken;
    logic [`BHT_DATA_WIDTH-1:0] history;
    logic [1:0]                 lphr;
    // stack pointer seen before this branch
    logic [`RAS_PTR_WIDTH-1:0]  ras_ptr;
  } correct_t;

endpackage

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // bit 0 is the slot at the aligned address, bit 1 the slot at +4
  typedef logic [1:0] slot_mask_t;

  typedef struct packed {
    // 8-byte aligned, bit 2 always clear
    logic [31:0]            pc;
    slot_mask_t             mask;
    bpu_pkg::predict_meta_t meta;
  } fetch_packet_t;

endpackage

`default_nettype wire

//--- source/fetch_credit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_credit_if;

  // push is only legal while the producer holds a credit
  logic                     push;
  fetch_pkg::fetch_packet_t packet;
  logic                     flush;
  // one pulse per pop
  logic                     credit_return;

  modport producer (
    output push,
    output packet,
    output flush,
    input  credit_return
  );

  modport buffer (
    input  push,
    input  packet,
    input  flush,
    output credit_return
  );

endinterface

`default_nettype wire

//--- source/predict_table_ram.sv
`timescale 1ns/1ps
`default_nettype none

module predict_table_ram #(
  parameter int data_width   = 8,
  parameter int depth        = 64,
  parameter int read_latency = 1
) (
  input  logic                         clk,
  input  logic                         we_i,
  input  logic [$clog2(depth)-1:0]     waddr_i,
  input  logic [data_width-1:0]        wdata_i,
  input  logic                         re_i,
  input  logic [$clog2(depth)-1:0]     raddr_i,
  output logic [data_width-1:0]        rdata_o
);

  logic [data_width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  if (read_latency == 0) begin : g_comb_read
    assign rdata_o = re_i ? mem[raddr_i] : '0;
  end else begin : g_reg_read
    logic [data_width-1:0] rdata_q;

    // holds its value while re_i is low
    always_ff @(posedge clk) begin
      if (re_i) begin
        rdata_q <= mem[raddr_i];
      end
    end

    assign rdata_o = rdata_q;
  end

endmodule

`default_nettype wire

//--- source/npc_predictor.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module npc_predictor (
  input  logic              clk,
  input  logic              rst_n,
  input  bpu_pkg::correct_t correct_i,
  fetch_credit_if.producer  fq
);

  localparam int credit_width = $clog2(`FETCH_QUEUE_DEPTH + 1);
  localparam int btb_depth    = 1 << `BTB_ADDR_WIDTH;
  localparam int hist_pc_bits = `LPHT_ADDR_WIDTH - `BHT_DATA_WIDTH;

  function automatic logic [`BTB_ADDR_WIDTH-1:0] btb_index(input logic [31:0] addr);
    return addr[`BTB_ADDR_WIDTH+2:3];
  endfunction

  function automatic logic [`BTB_TAG_WIDTH-1:0] btb_tag(input logic [31:0] addr);
    return addr[`BTB_TAG_WIDTH+`BTB_ADDR_WIDTH+2:`BTB_ADDR_WIDTH+3];
  endfunction

  // two pc fields folded together
  function automatic logic [`BHT_ADDR_WIDTH-1:0] bht_index(input logic [31:0] addr);
    return addr[`BHT_ADDR_WIDTH+2:3] ^ addr[2*`BHT_ADDR_WIDTH+2:`BHT_ADDR_WIDTH+3];
  endfunction

  function automatic logic [`LPHT_ADDR_WIDTH-1:0] lpht_index(
    input logic [31:0]                addr,
    input logic [`BHT_DATA_WIDTH-1:0] hist
  );
    return {addr[10 +: hist_pc_bits], hist};
  endfunction

  // walks 00 -> 01 -> 10 -> 11 on taken, back down on not taken
  function automatic logic [1:0] next_lphr(input logic [1:0] state, input logic dir);
    case (state)
      2'b01:   return {dir, 1'b0};
      2'b10:   return {dir, 1'b1};
      2'b11:   return {1'b1, dir};
      default: return {1'b0, dir};
    endcase
  endfunction

  logic [31:0]                pc_q;
  logic [31:0]                ppc;
  logic [31:0]                seq_pc;
  logic [31:0]                branch_pc;
  logic [31:0]                pred_target;
  logic [credit_width-1:0]    credit_q;
  logic                       push;
  logic                       advance;

  bpu_pkg::btb_entry_t        btb_q;
  bpu_pkg::btb_entry_t        btb_wdata;
  logic [btb_depth-1:0]       btb_valid;
  logic                       btb_valid_q;
  logic                       hit;
  logic                       uncond;
  logic                       taken;
  fetch_pkg::slot_mask_t      mask;

  logic [`BHT_DATA_WIDTH-1:0] bht_data;
  logic [`BHT_DATA_WIDTH-1:0] bht_wdata;
  logic [1:0]                 lpht_data;
  logic [1:0]                 lpht_wdata;
  logic                       cond_we;

  logic [31:0]                ras_stack [1 << `RAS_PTR_WIDTH];
  logic [`RAS_PTR_WIDTH-1:0]  ras_ptr_q;
  logic [`RAS_PTR_WIDTH-1:0]  ras_top_ptr;
  logic                       ras_push;
  logic                       ras_pop;

  // btb output belongs to pc_q, it was read with ppc last advance
  assign hit    = btb_valid_q && (btb_q.tag == btb_tag(pc_q)) && (!pc_q[2] || btb_q.fsc);
  assign uncond = hit && btb_q.dir_type;

  assign ras_push    = uncond && (btb_q.branch_type == bpu_pkg::CALL);
  assign ras_pop     = uncond && (btb_q.branch_type == bpu_pkg::RETURN);
  assign ras_top_ptr = ras_ptr_q - 1'b1;

  assign branch_pc = {pc_q[31:3], btb_q.fsc, 2'b00};
  assign seq_pc    = {pc_q[31:3], 3'b000} + 32'd8;

  always_comb begin
    taken = 1'b0;
    if (hit) begin
      if (btb_q.dir_type) begin
        taken = btb_q.branch_type != bpu_pkg::NPC;
      end else begin
        taken = lpht_data[1];
      end
    end
  end

  always_comb begin
    pred_target = ras_pop ? ras_stack[ras_top_ptr] : {btb_q.target, 2'b00};
    if (correct_i.miss) begin
      ppc = correct_i.true_target;
    end else if (taken) begin
      ppc = pred_target;
    end else begin
      ppc = seq_pc;
    end
  end

  always_comb begin
    mask = pc_q[2] ? 2'b10 : 2'b11;
    // taken in slot 0 drops slot 1
    if (taken && !btb_q.fsc) begin
      mask = 2'b01;
    end
  end

  assign push    = (credit_q != '0) && !correct_i.miss;
  assign advance = push || correct_i.miss;

  assign fq.push  = push;
  assign fq.flush = correct_i.miss;

  always_comb begin
    fq.packet.pc           = {pc_q[31:3], 3'b000};
    fq.packet.mask         = mask;
    fq.packet.meta.ras_ptr = ras_ptr_q;
    fq.packet.meta.history = bht_data;
    fq.packet.meta.lphr    = lpht_data;
    fq.packet.meta.taken   = taken;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q        <= `FETCH_RESET_PC;
      btb_valid_q <= 1'b0;
      btb_valid   <= '0;
      credit_q    <= credit_width'(`FETCH_QUEUE_DEPTH);
      ras_ptr_q   <= '0;
    end else begin
      if (advance) begin
        pc_q        <= ppc;
        btb_valid_q <= btb_valid[btb_index(ppc)];
      end
      if (correct_i.miss) begin
        credit_q <= credit_width'(`FETCH_QUEUE_DEPTH);
      end else begin
        credit_q <= credit_q + credit_width'(fq.credit_return) - credit_width'(push);
      end
      if (correct_i.miss) begin
        btb_valid[btb_index(correct_i.pc)] <= 1'b1;
        case (correct_i.true_target_type)
          bpu_pkg::CALL:   ras_ptr_q <= correct_i.ras_ptr + 1'b1;
          bpu_pkg::RETURN: ras_ptr_q <= correct_i.ras_ptr - 1'b1;
          default:         ras_ptr_q <= correct_i.ras_ptr;
        endcase
      end else if (push && ras_push) begin
        ras_ptr_q <= ras_ptr_q + 1'b1;
      end else if (push && ras_pop) begin
        ras_ptr_q <= ras_top_ptr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (correct_i.miss) begin
      if (correct_i.true_target_type == bpu_pkg::CALL) begin
        ras_stack[correct_i.ras_ptr] <= correct_i.pc + 32'd4;
      end
    end else if (push && ras_push) begin
      ras_stack[ras_ptr_q] <= branch_pc + 32'd4;
    end
  end

  always_comb begin
    btb_wdata.fsc         = correct_i.pc[2];
    btb_wdata.target      = correct_i.true_target[31:2];
    btb_wdata.tag         = btb_tag(correct_i.pc);
    btb_wdata.dir_type    = correct_i.true_dir;
    btb_wdata.branch_type = correct_i.true_target_type;
  end

  // history and pattern only train on conditional branches
  assign cond_we    = correct_i.miss && !correct_i.true_dir;
  assign bht_wdata  = {correct_i.history[`BHT_DATA_WIDTH-2:0], correct_i.true_taken};
  assign lpht_wdata = next_lphr(correct_i.lphr, correct_i.true_taken);

  predict_table_ram #(
    .data_width  ($bits(bpu_pkg::btb_entry_t)),
    .depth       (btb_depth),
    .read_latency(1)
  ) u_btb (
    .clk    (clk),
    .we_i   (correct_i.miss),
    .waddr_i(btb_index(correct_i.pc)),
    .wdata_i(btb_wdata),
    .re_i   (advance),
    .raddr_i(btb_index(ppc)),
    .rdata_o(btb_q)
  );

  predict_table_ram #(
    .data_width  (`BHT_DATA_WIDTH),
    .depth       (1 << `BHT_ADDR_WIDTH),
    .read_latency(0)
  ) u_bht (
    .clk    (clk),
    .we_i   (cond_we),
    .waddr_i(bht_index(correct_i.pc)),
    .wdata_i(bht_wdata),
    .re_i   (1'b1),
    .raddr_i(bht_index(pc_q)),
    .rdata_o(bht_data)
  );

  // updated at the entry the prediction was read from
  predict_table_ram #(
    .data_width  (2),
    .depth       (1 << `LPHT_ADDR_WIDTH),
    .read_latency(0)
  ) u_lpht (
    .clk    (clk),
    .we_i   (cond_we),
    .waddr_i(lpht_index(correct_i.pc, correct_i.history)),
    .wdata_i(lpht_wdata),
    .re_i   (1'b1),
    .raddr_i(lpht_index(pc_q, bht_data)),
    .rdata_o(lpht_data)
  );

endmodule

`default_nettype wire

//--- source/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_queue (
  input  logic                     clk,
  input  logic                     rst_n,
  fetch_credit_if.buffer           fq,
  output logic                     q_valid_o,
  output fetch_pkg::fetch_packet_t q_packet_o,
  input  logic                     q_pop_i
);

  localparam int depth       = `FETCH_QUEUE_DEPTH;
  localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  function automatic logic [ptr_width-1:0] wrap_inc(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  fetch_pkg::fetch_packet_t entries [depth];
  logic [ptr_width-1:0]     wptr_q;
  logic [ptr_width-1:0]     rptr_q;
  logic [count_width-1:0]   count_q;
  logic                     write;
  logic                     pop;

  assign q_valid_o  = count_q != '0;
  assign q_packet_o = entries[rptr_q];

  // no full check, the producer never pushes without a credit
  assign write = fq.push && !fq.flush;
  assign pop   = q_pop_i && q_valid_o;

  assign fq.credit_return = pop;

  always_ff @(posedge clk) begin
    if (!rst_n || fq.flush) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (write) begin
        wptr_q <= wrap_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= wrap_inc(rptr_q);
      end
      count_q <= count_q + count_width'(write) - count_width'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      entries[wptr_q] <= fq.packet;
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_issue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_issue (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  logic                     q_valid_i,
  input  fetch_pkg::fetch_packet_t q_packet_i,
  output logic                     q_pop_o,
  input  logic                     issue_ready_i,
  output logic                     issue_valid_o,
  output logic [31:0]              issue_pc_o,
  output logic                     issue_taken_o
);

  fetch_pkg::slot_mask_t mask;
  // slot 0 of the head packet already went out
  logic                  slot0_done_q;
  logic                  cur_slot;
  logic                  last_slot;
  logic                  fire;

  assign mask = q_packet_i.mask;

  // skip slot 0 once issued or when masked off
  assign cur_slot  = slot0_done_q || !mask[0];
  assign last_slot = cur_slot || !mask[1];

  // nothing goes out in the cycle execute redirects
  assign issue_valid_o = q_valid_i && !flush_i;
  assign issue_pc_o    = {q_packet_i.pc[31:3], cur_slot, 2'b00};
  // a taken packet always ends at its branch
  assign issue_taken_o = last_slot && q_packet_i.meta.taken;

  assign fire    = issue_valid_o && issue_ready_i;
  assign q_pop_o = fire && last_slot;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      slot0_done_q <= 1'b0;
    end else if (fire) begin
      slot0_done_q <= !last_slot;
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       issue_ready_i,
  input  logic                       correct_miss_i,
  input  logic [31:0]                correct_pc_i,
  input  logic [31:0]                correct_target_i,
  input  logic [1:0]                 correct_type_i,
  input  logic                       correct_dir_i,
  input  logic                       correct_taken_i,
  input  logic [`BHT_DATA_WIDTH-1:0] correct_history_i,
  input  logic [1:0]                 correct_lphr_i,
  input  logic [`RAS_PTR_WIDTH-1:0]  correct_ras_ptr_i,
  output logic                       issue_valid_o,
  output logic [31:0]                issue_pc_o,
  output logic                       issue_taken_o
);

  bpu_pkg::correct_t        correct;
  logic                     q_valid;
  fetch_pkg::fetch_packet_t q_packet;
  logic                     q_pop;

  fetch_credit_if fq_if ();

  assign correct.miss             = correct_miss_i;
  assign correct.pc               = correct_pc_i;
  assign correct.true_target      = correct_target_i;
  assign correct.true_target_type = bpu_pkg::target_type_e'(correct_type_i);
  assign correct.true_dir         = correct_dir_i;
  assign correct.true_taken       = correct_taken_i;
  assign correct.history          = correct_history_i;
  assign correct.lphr             = correct_lphr_i;
  assign correct.ras_ptr          = correct_ras_ptr_i;

  npc_predictor u_predictor (
    .clk      (clk),
    .rst_n    (rst_n),
    .correct_i(correct),
    .fq       (fq_if.producer)
  );

  fetch_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .fq        (fq_if.buffer),
    .q_valid_o (q_valid),
    .q_packet_o(q_packet),
    .q_pop_i   (q_pop)
  );

  fetch_issue u_issue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (fq_if.flush),
    .q_valid_i    (q_valid),
    .q_packet_i   (q_packet),
    .q_pop_o      (q_pop),
    .issue_ready_i(issue_ready_i),
    .issue_valid_o(issue_valid_o),
    .issue_pc_o   (issue_pc_o),
    .issue_taken_o(issue_taken_o)
  );

endmodule

`default_nettype wire

//--- verification/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_tb;

  localparam int cycles_per_line = 40;
  localparam int max_lines       = 256;

  logic                       clk;
  logic                       rst_n;
  logic                       issue_ready;
  logic                       correct_miss;
  logic [31:0]                correct_pc;
  logic [31:0]                correct_target;
  logic [1:0]                 correct_type;
  logic                       correct_dir;
  logic                       correct_taken;
  logic [`BHT_DATA_WIDTH-1:0] correct_history;
  logic [1:0]                 correct_lphr;
  logic [`RAS_PTR_WIDTH-1:0]  correct_ras_ptr;
  logic                       issue_valid;
  logic [31:0]                issue_pc;
  logic                       issue_taken;

  // one entry per command line of the data file
  logic [7:0]                 line_kind   [max_lines];
  logic                       line_miss   [max_lines];
  logic [31:0]                line_pc     [max_lines];
  logic [31:0]                line_target [max_lines];
  logic [1:0]                 line_type   [max_lines];
  logic                       line_dir    [max_lines];
  logic                       line_taken  [max_lines];
  logic [`BHT_DATA_WIDTH-1:0] line_hist   [max_lines];
  logic [1:0]                 line_lphr   [max_lines];
  logic [`RAS_PTR_WIDTH-1:0]  line_ras    [max_lines];
  int                         line_count  [max_lines];
  int                         line_level  [max_lines];
  int                         num_lines;

  // {taken, pc} of issues still to come
  logic [32:0]                exp_q [$];
  int                         cycle_count;
  int                         cycle_limit;

  fetch_top uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .issue_ready_i    (issue_ready),
    .correct_miss_i   (correct_miss),
    .correct_pc_i     (correct_pc),
    .correct_target_i (correct_target),
    .correct_type_i   (correct_type),
    .correct_dir_i    (correct_dir),
    .correct_taken_i  (correct_taken),
    .correct_history_i(correct_history),
    .correct_lphr_i   (correct_lphr),
    .correct_ras_ptr_i(correct_ras_ptr),
    .issue_valid_o    (issue_valid),
    .issue_pc_o       (issue_pc),
    .issue_taken_o    (issue_taken)
  );

  always #4 clk = ~clk;

  task automatic read_data_file();
    int                         fd;
    int                         code;
    logic [7:0]                 kind;
    logic [8*256-1:0]           rest;
    logic                       miss;
    logic [31:0]                pc;
    logic [31:0]                target;
    logic [1:0]                 ctype;
    logic                       dir;
    logic                       taken;
    logic [`BHT_DATA_WIDTH-1:0] hist;
    logic [1:0]                 lphr;
    logic [`RAS_PTR_WIDTH-1:0]  ras;
    int                         count;
    int                         level;
    fd = $fopen("verification/fetch_testdata.txt", "r");
    if (fd == 0) begin
      $display("Test failures found");
      $fatal(1, "could not open verification/fetch_testdata.txt");
    end
    num_lines = 0;
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", kind);
      if (code == 1 && kind == "#") begin
        code = $fgets(rest, fd);
      end else if (code == 1) begin
        if (num_lines >= max_lines) begin
          $display("Test failures found");
          $fatal(1, "the data file has more command lines than the testbench can hold");
        end
        line_kind[num_lines] = kind;
        case (kind)
          "C": begin
            code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h",
                           miss, pc, target, ctype, dir, taken, hist, lphr, ras);
            line_miss[num_lines]   = miss;
            line_pc[num_lines]     = pc;
            line_target[num_lines] = target;
            line_type[num_lines]   = ctype;
            line_dir[num_lines]    = dir;
            line_taken[num_lines]  = taken;
            line_hist[num_lines]   = hist;
            line_lphr[num_lines]   = lphr;
            line_ras[num_lines]    = ras;
            code = (code == 9) ? 1 : 0;
          end
          "R": begin
            code = $fscanf(fd, " %d %d", count, level);
            line_count[num_lines] = count;
            line_level[num_lines] = level;
            code = (code == 2) ? 1 : 0;
          end
          "E": begin
            code = $fscanf(fd, " %h %h", pc, taken);
            line_pc[num_lines]    = pc;
            line_taken[num_lines] = taken;
            code = (code == 2) ? 1 : 0;
          end
          default: code = 0;
        endcase
        if (code != 1) begin
          $display("Test failures found");
          $fatal(1, "data file line %0d could not be parsed", num_lines + 1);
        end
        num_lines++;
      end
    end
    $fclose(fd);
  endtask

  // waits for the stream so far, then redirects for one cycle
  task automatic apply_correction(input int idx);
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    correct_miss    = line_miss[idx];
    correct_pc      = line_pc[idx];
    correct_target  = line_target[idx];
    correct_type    = line_type[idx];
    correct_dir     = line_dir[idx];
    correct_taken   = line_taken[idx];
    correct_history = line_hist[idx];
    correct_lphr    = line_lphr[idx];
    correct_ras_ptr = line_ras[idx];
    @(posedge clk);
    #1;
    correct_miss = 1'b0;
  endtask

  task automatic hold_ready(input int cycles, input int level);
    issue_ready = (level != 0);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
    issue_ready = 1'b1;
  endtask

  // issues outside a checked window are wrong-path leftovers
  always @(posedge clk) begin : check_issue
    logic [32:0] exp_entry;
    if (rst_n && issue_valid && issue_ready && exp_q.size() != 0) begin
      exp_entry = exp_q.pop_front();
      assert (issue_pc == exp_entry[31:0]) else begin
        $display("[FAIL] issue_pc_o expected %h got %h", exp_entry[31:0], issue_pc);
        $display("Test failures found");
        $fatal(1, "issue stream mismatch");
      end
      assert (issue_taken == exp_entry[32]) else begin
        $display("[FAIL] issue_taken_o expected %h got %h", exp_entry[32], issue_taken);
        $display("Test failures found");
        $fatal(1, "issue stream mismatch");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Test failures found");
      $fatal(1, "timed out after %0d cycles without finishing the data file", cycle_count);
    end
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    issue_ready     = 1'b1;
    correct_miss    = 1'b0;
    correct_pc      = '0;
    correct_target  = '0;
    correct_type    = '0;
    correct_dir     = 1'b0;
    correct_taken   = 1'b0;
    correct_history = '0;
    correct_lphr    = '0;
    correct_ras_ptr = '0;
    cycle_count     = 0;
    cycle_limit     = cycles_per_line;
    read_data_file();
    cycle_limit = cycles_per_line * num_lines;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < num_lines; i++) begin
      case (line_kind[i])
        "C":     apply_correction(i);
        "R":     hold_ready(line_count[i], line_level[i]);
        default: exp_q.push_back({line_taken[i], line_pc[i]});
      endcase
    end
    // any issue still missing ends the run through the cycle counter
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/fetch_testdata.txt
# C miss pc target type dir taken history lphr ras_ptr (hex); type 0 npc 1 call 2 return 3 jump
# R cycles level (decimal) holds issue ready; E pc taken (hex) is the next expected issue
E 1c000000 0
E 1c000004 0
E 1c000008 0
E 1c00000c 0
# redirect into slot 1, then stall long enough to fill the queue
C 1 1c000100 1c000044 0 1 0 0 0 0
E 1c000044 0
E 1c000048 0
R 30 0
E 1c00004c 0
E 1c000050 0
E 1c000054 0
E 1c000058 0
E 1c00005c 0
E 1c000060 0
# jump at 80 to 120, then refetch from 70
C 1 1c000080 1c000120 3 1 1 0 0 0
E 1c000120 0
C 1 1c000100 1c000070 0 1 0 0 0 0
E 1c000070 0
E 1c000074 0
E 1c000078 0
E 1c00007c 0
E 1c000080 1
E 1c000120 0
# call at 88 to 180, return at 190
C 1 1c000088 1c000180 1 1 1 0 0 0
E 1c000180 0
C 1 1c000190 1c00008c 2 1 1 0 0 1
E 1c00008c 0
C 1 1c000100 1c000088 0 1 0 0 0 0
E 1c000088 1
E 1c000180 0
E 1c000184 0
E 1c000188 0
E 1c00018c 0
E 1c000190 1
E 1c00008c 0
E 1c000090 0
# conditional at a4, trained taken twice with history f
C 1 1c0000a4 1c000140 3 0 1 f 0 0
E 1c000140 0
C 1 1c000100 1c0000a0 0 1 0 0 0 0
E 1c0000a0 0
E 1c0000a4 0
E 1c0000a8 0
C 1 1c0000a4 1c000140 3 0 1 f 1 0
E 1c000140 0
C 1 1c000100 1c0000a0 0 1 0 0 0 0
E 1c0000a0 0
E 1c0000a4 1
E 1c000140 0

//--- sim.f
+incdir+source
source/bpu_pkg.sv
source/fetch_pkg.sv
source/fetch_credit_if.sv
source/predict_table_ram.sv
source/npc_predictor.sv
source/fetch_queue.sv
source/fetch_issue.sv
source/fetch_top.sv
verification/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f sim.f -o vfetch_tb &&
  ./obj_dir/vfetch_tb ||
  exit 1
